// ==== sources.f ====
verilog/icache_cfg_pkg.sv
verilog/icache_if_pkg.sv
verilog/icache_sram.sv
verilog/icache_store.sv
verilog/icache_repl.sv
verilog/icache_lookup.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # packages first, then the arrays and the control
  - verilog/icache_cfg_pkg.sv
  - verilog/icache_if_pkg.sv
  - verilog/icache_sram.sv
  - verilog/icache_store.sv
  - verilog/icache_repl.sv
  - verilog/icache_lookup.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - tb/icache_asserts.sv
      - tb/icache_tb.sv

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
;

  localparam int unsigned reset_cycles = 16;
  localparam int unsigned n_rand_ops   = 60;
  // directed tests issue 40 operations, requests and flushes together
  localparam int unsigned max_ops      = 40 + n_rand_ops;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  icache_fetch_req_t fetch_req;
  icache_fetch_rsp_t fetch_rsp;
  icache_mem_req_t   mem_req;
  logic              mem_ack;
  icache_mem_rtrn_t  mem_rtrn;
  logic              miss;

  // accepted requests waiting for their response
  icache_paddr_t pend_addr [$];
  int unsigned   pend_cyc [$];
  icache_paddr_t exp_addr;

  int unsigned cycle_cnt = 0;
  int unsigned mem_cnt   = 0;
  int unsigned miss_cnt  = 0;
  int unsigned fast_cnt  = 0;
  int unsigned rsp_cnt   = 0;
  int unsigned chk_cnt   = 0;
  int unsigned err_cnt   = 0;
  int unsigned issued    = 0;
  int unsigned last_lat  = 0;
  // baselines at the start of each test
  int unsigned mem0, miss0, fast0, err0;

  icache_top #(
    .NumWays  (num_ways),
    .NumSets  (num_sets),
    .LfsrWidth(8)
  ) icache_top_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .fetch_req_i(fetch_req),
    .fetch_rsp_o(fetch_rsp),
    .mem_req_o  (mem_req),
    .mem_ack_i  (mem_ack),
    .mem_rtrn_i (mem_rtrn),
    .miss_o     (miss)
  );

  bind icache_top icache_asserts i_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_rsp_i(fetch_rsp_o),
    .mem_req_i  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .miss_i     (miss_o)
  );

  ////////////////////////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////////////////////////

  // memory content, a hash of the full word address
  function automatic icache_word_t ref_word(input icache_paddr_t addr);
    icache_paddr_t w;
    w = {addr[paddr_width-1:2], 2'b00};
    return (w * 32'h9E37_79B1) ^ {w[15:0], w[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  // uncached fetches ask for their word, cached ones for the whole line
  function automatic icache_mem_req_t ref_mem_req(input icache_paddr_t addr);
    icache_mem_req_t r;
    r.req  = 1'b1;
    r.nc   = addr[nc_bit];
    r.addr = r.nc ? (addr & ~32'h3) : (addr & ~32'hF);
    return r;
  endfunction

  task automatic check_word(input icache_paddr_t addr, input icache_word_t got,
                            input icache_word_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: word at %h got %h expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic check_mem_req(input icache_paddr_t addr, input icache_mem_req_t got,
                               input icache_mem_req_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: mem request for %h got %h nc %0b expected %h nc %0b",
               $time, addr, got.addr, got.nc, exp.addr, exp.nc);
    end
  endtask

  task automatic check_count(input string what, input int unsigned got,
                             input int unsigned exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s is %0d expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // clock, memory model and response compare
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ack after 0 to 3 cycles, line back 1 to 4 cycles after the ack
  initial begin : mem_model
    icache_paddr_t req_addr;
    int unsigned   delay;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req.req) begin
        req_addr = mem_req.addr;
        // the request belongs to the fetch accepted last
        check_mem_req(pend_addr[$], mem_req, ref_mem_req(pend_addr[$]));
        delay    = $urandom_range(3, 0);
        repeat (delay) @(negedge clk_i);
        mem_ack = 1'b1;
        @(negedge clk_i);
        mem_ack = 1'b0;
        delay   = $urandom_range(4, 1);
        repeat (delay - 1) @(negedge clk_i);
        // whole line, the word for an uncached fetch sits at its offset
        for (int i = 0; i < line_width / fetch_width; i++) begin
          mem_rtrn.line[i*fetch_width +: fetch_width] =
              ref_word({req_addr[paddr_width-1:offset_width], 4'h0} + 4 * i);
        end
        mem_rtrn.valid = 1'b1;
        @(negedge clk_i);
        mem_rtrn.valid = 1'b0;
      end
    end
  end

  // values sampled here are the ones settled before the edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt++;
      if (mem_req.req && mem_ack) begin
        mem_cnt++;
      end
      if (miss) begin
        miss_cnt++;
      end
      if (fetch_rsp.valid) begin
        if (pend_addr.size() == 0) begin
          err_cnt++;
          $display("%0t ns: a response came with no request outstanding", $time);
        end else begin
          exp_addr = pend_addr.pop_front();
          last_lat = cycle_cnt - pend_cyc.pop_front();
          if (last_lat == 1) begin
            fast_cnt++;
          end
          rsp_cnt++;
          check_word(exp_addr, fetch_rsp.data, ref_word(exp_addr));
        end
      end
      // pop before push, a hit response and the next accept share a cycle
      if (fetch_req.req && fetch_rsp.ready) begin
        pend_addr.push_back(fetch_req.addr);
        pend_cyc.push_back(cycle_cnt);
      end
    end
  end

  initial begin : watchdog
    repeat (reset_cycles + num_sets + 200 * max_ops) @(posedge clk_i);
    $display("timeout: the run did not finish in time, %0d responses seen", rsp_cnt);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // leaves req high, so calls in a row stream
  task automatic fetch(input icache_paddr_t addr);
    @(negedge clk_i);
    fetch_req.req  = 1'b1;
    fetch_req.addr = addr;
    @(posedge clk_i);
    while (!fetch_rsp.ready) begin
      @(posedge clk_i);
    end
    issued++;
  endtask

  task automatic idle_req();
    @(negedge clk_i);
    fetch_req.req = 1'b0;
  endtask

  task automatic drain();
    while (pend_addr.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic fetch_one(input icache_paddr_t addr);
    fetch(addr);
    idle_req();
    drain();
  endtask

  // flush pulse from idle, counts the cycles with ready low
  task automatic do_flush(output int unsigned low_cycles);
    low_cycles = 0;
    @(negedge clk_i);
    flush_i = 1'b1;
    @(posedge clk_i);
    if (!fetch_rsp.ready) begin
      low_cycles++;
    end
    @(negedge clk_i);
    flush_i = 1'b0;
    @(posedge clk_i);
    while (!fetch_rsp.ready) begin
      low_cycles++;
      @(posedge clk_i);
    end
  endtask

  task automatic start_test();
    mem0  = mem_cnt;
    miss0 = miss_cnt;
    fast0 = fast_cnt;
  endtask

  task automatic end_test(input int unsigned num, input string name);
    $display("test %0d %s: done, %0d errors", num, name, err_cnt - err0);
    err0 = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned   seed_val;
    int unsigned   low;
    int unsigned   op;
    int unsigned   nc_cnt;
    icache_paddr_t addr;

    seed_val  = $urandom(32'h5b34);
    nc_cnt    = 0;
    err0      = 0;
    rst_ni    = 1'b0;
    flush_i   = 1'b0;
    fetch_req = '0;
    mem_ack   = 1'b0;
    mem_rtrn  = '0;
    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    while (!fetch_rsp.ready) begin
      @(posedge clk_i);
    end

    // cold miss, then a hit in the same line
    start_test();
    fetch_one(32'h0000_1004);
    check_count("cold miss mem requests", mem_cnt - mem0, 1);
    check_count("cold miss pulses", miss_cnt - miss0, 1);
    start_test();
    fetch_one(32'h0000_1008);
    check_count("hit mem requests", mem_cnt - mem0, 0);
    check_count("hit latency", last_lat, 1);
    end_test(1, "cold miss then hit");

    // warm three more lines, then stream every word of the four
    fetch_one(32'h0000_1010);
    fetch_one(32'h0000_1020);
    fetch_one(32'h0000_1030);
    start_test();
    for (int i = 0; i < 16; i++) begin
      fetch(32'h0000_1000 + 4 * i);
    end
    idle_req();
    drain();
    check_count("stream mem requests", mem_cnt - mem0, 0);
    check_count("stream single cycle hits", fast_cnt - fast0, 16);
    end_test(2, "back-to-back hits");

    // uncached, repeats go to memory again
    start_test();
    fetch_one(32'h8000_2004);
    fetch_one(32'h8000_2004);
    fetch_one(32'h8000_2008);
    fetch_one(32'h8000_2004);
    check_count("uncached mem requests", mem_cnt - mem0, 4);
    check_count("uncached miss pulses", miss_cnt - miss0, 0);
    end_test(3, "uncached region");

    // pending flush taken in idle, then one set per cycle
    start_test();
    do_flush(low);
    check_count("flush cycles with ready low", low, num_sets + 1);
    for (int i = 0; i < 4; i++) begin
      fetch_one(32'h0000_1000 + 16 * i);
    end
    check_count("misses after flush", miss_cnt - miss0, 4);
    end_test(4, "flush");

    // five tags in set 0xa
    start_test();
    for (int i = 0; i < 4; i++) begin
      fetch_one(32'h0002_00A0 + (i << 8));
    end
    check_count("set fill misses", miss_cnt - miss0, 4);
    start_test();
    for (int i = 0; i < 4; i++) begin
      fetch_one(32'h0002_00A4 + (i << 8));
    end
    check_count("set reread misses", miss_cnt - miss0, 0);
    fetch_one(32'h0002_04AC);
    fetch_one(32'h0002_04A8);
    check_count("fifth tag misses", miss_cnt - miss0, 1);
    end_test(5, "invalid-first replacement");

    // random mix, eight tags per set in the cached part
    start_test();
    for (int i = 0; i < n_rand_ops; i++) begin
      op = $urandom_range(9, 0);
      if (op == 0) begin
        do_flush(low);
      end else if (op <= 2) begin
        addr = 32'h8000_0000 | ($urandom & 32'h0000_03FC);
        fetch_one(addr);
        nc_cnt++;
      end else begin
        addr = 32'h0003_0000 | (($urandom & 32'h7) << 8) | ($urandom & 32'hFC);
        fetch_one(addr);
      end
    end
    // every uncached fetch is one mem request that is not a miss
    check_count("uncached share of mem requests",
                (mem_cnt - mem0) - (miss_cnt - miss0), nc_cnt);
    end_test(6, "random mix");

    $display("summary: %0d requests, %0d responses, %0d checks, %0d errors, %0d assertion fails",
             issued, rsp_cnt, chk_cnt, err_cnt, icache_top_i.i_asserts.fail_cnt);
    if (err_cnt == 0 && icache_top_i.i_asserts.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/icache_asserts.sv ====
`timescale 1ns/1ps

module icache_asserts
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input icache_fetch_rsp_t fetch_rsp_i,
  input icache_mem_req_t   mem_req_i,
  input logic              mem_ack_i,
  input logic              miss_i
);

  // failed assertions, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // memory port
  ////////////////////////////////////////////////////////////

  // request and address held until the ack
  property p_req_hold;
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.req && !mem_ack_i |=>
      mem_req_i.req && $stable(mem_req_i.addr) && $stable(mem_req_i.nc);
  endproperty

  req_hold_a : assert property (p_req_hold)
    else begin
      fail_cnt++;
      $error("mem req dropped or address changed before ack");
    end

  // a miss is counted only when the refill request is acked
  property p_miss_ack;
    @(posedge clk_i) disable iff (!rst_ni)
    miss_i |-> mem_req_i.req && mem_ack_i;
  endproperty

  miss_ack_a : assert property (p_miss_ack)
    else begin
      fail_cnt++;
      $error("miss pulse without an acked mem request");
    end

  ////////////////////////////////////////////////////////////
  // reset flush
  ////////////////////////////////////////////////////////////

  // one set cleared per cycle, no fetch accepted meanwhile
  property p_flush_ready;
    @(posedge clk_i)
    $rose(rst_ni) |-> !fetch_rsp_i.ready [*num_sets];
  endproperty

  flush_ready_a : assert property (p_flush_ready)
    else begin
      fail_cnt++;
      $error("ready high during the reset flush");
    end

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps

module icache_top
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
#(
  parameter int unsigned NumWays   = num_ways,
  parameter int unsigned NumSets   = num_sets,
  parameter int unsigned LfsrWidth = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  icache_fetch_req_t fetch_req_i,
  output icache_fetch_rsp_t fetch_rsp_o,
  output icache_mem_req_t   mem_req_o,
  input  logic              mem_ack_i,
  input  icache_mem_rtrn_t  mem_rtrn_i,
  output logic              miss_o
);

  icache_ctrl_t                    ctrl;
  icache_tag_entry_t [NumWays-1:0] tags;
  icache_line_t [NumWays-1:0]      lines;
  logic [NumWays-1:0]              valid_bits;
  logic [NumWays-1:0]              victim_oh;
  logic                            capture;
  logic                            use_rtrn;
  logic                            hit;
  icache_word_t                    word;
  logic [tag_width-1:0]            tag;
  logic [offset_width-1:0]         offset;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  icache_ctrl #(
    .NumSets(NumSets)
  ) i_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .fetch_req_i(fetch_req_i),
    .fetch_rsp_o(fetch_rsp_o),
    .mem_req_o  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .mem_rtrn_i (mem_rtrn_i),
    .hit_i      (hit),
    .word_i     (word),
    .ctrl_o     (ctrl),
    .capture_o  (capture),
    .use_rtrn_o (use_rtrn),
    .tag_o      (tag),
    .offset_o   (offset),
    .miss_o     (miss_o)
  );

  ////////////////////////////////////////////////////////////
  // arrays, victim choice and lookup
  ////////////////////////////////////////////////////////////

  icache_store #(
    .NumWays(NumWays),
    .NumSets(NumSets)
  ) i_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ctrl_i     (ctrl),
    .victim_oh_i(victim_oh),
    .rtrn_line_i(mem_rtrn_i.line),
    .tags_o     (tags),
    .lines_o    (lines)
  );

  // valid bits of the set being looked up
  for (genvar i = 0; i < NumWays; i++) begin : gen_valid
    assign valid_bits[i] = tags[i].valid;
  end

  icache_repl #(
    .NumWays  (NumWays),
    .LfsrWidth(LfsrWidth)
  ) i_repl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_bits_i(valid_bits),
    .capture_i   (capture),
    .wren_i      (ctrl.wren),
    .victim_oh_o (victim_oh)
  );

  icache_lookup #(
    .NumWays(NumWays)
  ) i_lookup (
    .tags_i     (tags),
    .lines_i    (lines),
    .tag_i      (tag),
    .offset_i   (offset),
    .use_rtrn_i (use_rtrn),
    .rtrn_line_i(mem_rtrn_i.line),
    .hit_o      (hit),
    .word_o     (word)
  );

endmodule

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
#(
  parameter int unsigned NumSets = num_sets
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  icache_fetch_req_t       fetch_req_i,
  output icache_fetch_rsp_t       fetch_rsp_o,
  output icache_mem_req_t         mem_req_o,
  input  logic                    mem_ack_i,
  input  icache_mem_rtrn_t        mem_rtrn_i,
  input  logic                    hit_i,
  input  icache_word_t            word_i,
  output icache_ctrl_t            ctrl_o,
  output logic                    capture_o,
  output logic                    use_rtrn_o,
  output logic [tag_width-1:0]    tag_o,
  output logic [offset_width-1:0] offset_o,
  output logic                    miss_o
);

  localparam int unsigned tag_lsb = offset_width + index_width;

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

  state_e                 state_d, state_q;
  icache_paddr_t          addr_d, addr_q;
  logic                   flush_d, flush_q;
  logic [index_width-1:0] flush_cnt_d, flush_cnt_q;
  logic                   flush_done;
  logic                   accept;
  logic                   is_nc;
  logic                   ready;
  logic                   valid;
  logic                   mem_req;
  icache_paddr_t          mem_addr;
  logic                   rden;
  logic                   wren;
  logic                   flush_en;
  logic [index_width-1:0] index;

  ////////////////////////////////////////////////////////////
  // address split and memory request
  ////////////////////////////////////////////////////////////

  assign is_nc    = addr_q[nc_bit];
  assign tag_o    = addr_q[paddr_width-1:tag_lsb];
  assign offset_o = addr_q[offset_width-1:0];

  // uncached fetches ask for the word, cached ones for the line
  assign mem_addr = is_nc ? {addr_q[paddr_width-1:2], 2'b00} :
                            {addr_q[paddr_width-1:offset_width], {offset_width{1'b0}}};

  assign mem_req_o   = '{req: mem_req, addr: mem_addr, nc: is_nc};
  assign fetch_rsp_o = '{ready: ready, valid: valid, data: word_i};
  assign ctrl_o      = '{rden: rden, wren: wren, flush_en: flush_en,
                         index: index, tag: tag_o};

  // victim is taken from the tags read out for this request
  assign capture_o  = (state_q == READ);
  // word comes straight from the return line on a refill
  assign use_rtrn_o = (state_q == MISS);

  assign addr_d = accept ? fetch_req_i.addr : addr_q;

  // one set cleared per cycle
  assign flush_done  = (flush_cnt_q == index_width'(NumSets - 1));
  assign flush_cnt_d = !flush_en  ? flush_cnt_q :
                       flush_done ? '0 : flush_cnt_q + 1'b1;

  ////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    // flush waits as pending until IDLE
    flush_d  = flush_q | flush_i;
    flush_en = 1'b0;
    rden     = 1'b0;
    wren     = 1'b0;
    accept   = 1'b0;
    ready    = 1'b0;
    valid    = 1'b0;
    mem_req  = 1'b0;
    miss_o   = 1'b0;
    // latched set by default, used by the refill write
    index    = addr_q[tag_lsb-1:offset_width];

    unique case (state_q)
      // clear all valid bits
      FLUSH: begin
        flush_en = 1'b1;
        index    = flush_cnt_q;
        if (flush_done) begin
          flush_d = 1'b0;
          state_d = IDLE;
        end
      end
      // take a pending flush, else accept a fetch
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          ready = 1'b1;
          if (fetch_req_i.req) begin
            accept  = 1'b1;
            rden    = 1'b1;
            index   = fetch_req_i.addr[tag_lsb-1:offset_width];
            state_d = READ;
          end
        end
      end
      // tags are out, decide hit or go to memory
      READ: begin
        if (hit_i && !is_nc) begin
          valid   = 1'b1;
          state_d = IDLE;
          // next lookup overlaps with this response
          if (!flush_d) begin
            ready = 1'b1;
            if (fetch_req_i.req) begin
              accept  = 1'b1;
              rden    = 1'b1;
              index   = fetch_req_i.addr[tag_lsb-1:offset_width];
              state_d = READ;
            end
          end
        end else begin
          // uncached fetches always land here
          mem_req = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~is_nc;
            state_d = MISS;
          end
        end
      end
      // wait for the line, never write an uncached one
      MISS: begin
        if (mem_rtrn_i.valid) begin
          valid   = 1'b1;
          wren    = ~is_nc;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      addr_q      <= addr_d;
    end
  end

endmodule

// ==== verilog/icache_lookup.sv ====
`timescale 1ns/1ps

module icache_lookup
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
#(
  parameter int unsigned NumWays = num_ways
) (
  input  icache_tag_entry_t [NumWays-1:0] tags_i,
  input  icache_line_t [NumWays-1:0]      lines_i,
  input  logic [tag_width-1:0]            tag_i,
  input  logic [offset_width-1:0]         offset_i,
  input  logic                            use_rtrn_i,
  input  icache_line_t                    rtrn_line_i,
  output logic                            hit_o,
  output icache_word_t                    word_o
);

  localparam int unsigned way_w  = $clog2(NumWays);
  localparam int unsigned word_w = offset_width - $clog2(fetch_width / 8);

  logic [NumWays-1:0] way_hit;
  logic [way_w-1:0]   hit_idx;
  logic [word_w-1:0]  word_idx;
  icache_line_t       sel_line;

  // tag compare per way
  for (genvar i = 0; i < NumWays; i++) begin : gen_cmp
    assign way_hit[i] = tags_i[i].valid && (tags_i[i].tag == tag_i);
  end

  // hit way encoding, lowest index wins
  always_comb begin
    hit_idx = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        hit_idx = way_w'(i);
      end
    end
  end

  assign hit_o = |way_hit;

  // refill data bypasses the arrays
  assign sel_line = use_rtrn_i ? rtrn_line_i : lines_i[hit_idx];

  // low two offset bits dropped, fetches are word aligned
  assign word_idx = offset_i[offset_width-1:offset_width-word_w];
  assign word_o   = sel_line[word_idx*fetch_width +: fetch_width];

endmodule

// ==== verilog/icache_repl.sv ====
`timescale 1ns/1ps

module icache_repl
  import icache_cfg_pkg::*;
#(
  parameter int unsigned NumWays   = num_ways,
  parameter int unsigned LfsrWidth = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NumWays-1:0] valid_bits_i,
  input  logic               capture_i,
  input  logic               wren_i,
  output logic [NumWays-1:0] victim_oh_o
);

  localparam int unsigned way_w = $clog2(NumWays);
  // galois masks, other widths fall back to a two-tap mask
  localparam logic [LfsrWidth-1:0] lfsr_taps =
      (LfsrWidth == 8)  ? LfsrWidth'('hB8) :
      (LfsrWidth == 16) ? LfsrWidth'('hB400) :
      {1'b1, {(LfsrWidth-2){1'b0}}, 1'b1};

  logic [LfsrWidth-1:0] lfsr_d, lfsr_q;
  logic [way_w-1:0]     inv_way;
  logic [way_w-1:0]     repl_way;
  logic                 all_valid;
  logic [NumWays-1:0]   victim_oh_d, victim_oh_q;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!valid_bits_i[i]) begin
        inv_way = way_w'(i);
      end
    end
  end

  assign all_valid = &valid_bits_i;
  // random pick only once the set is full
  assign repl_way  = all_valid ? lfsr_q[way_w-1:0] : inv_way;

  always_comb begin
    victim_oh_d           = '0;
    victim_oh_d[repl_way] = 1'b1;
  end

  // lfsr steps on every refill that evicts a line
  assign lfsr_d = (wren_i && all_valid) ?
                  (lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_taps) : (lfsr_q >> 1)) :
                  lfsr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= LfsrWidth'(1);
      victim_oh_q <= '0;
    end else begin
      lfsr_q <= lfsr_d;
      // hold the victim until the refill comes back
      if (capture_i) begin
        victim_oh_q <= victim_oh_d;
      end
    end
  end

  assign victim_oh_o = victim_oh_q;

endmodule

// ==== verilog/icache_store.sv ====
`timescale 1ns/1ps

module icache_store
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
#(
  parameter int unsigned NumWays = num_ways,
  parameter int unsigned NumSets = num_sets
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  icache_ctrl_t                    ctrl_i,
  input  logic [NumWays-1:0]              victim_oh_i,
  input  icache_line_t                    rtrn_line_i,
  output icache_tag_entry_t [NumWays-1:0] tags_o,
  output icache_line_t [NumWays-1:0]      lines_o
);

  localparam int unsigned addr_w = $clog2(NumSets);

  logic [addr_w-1:0]  addr;
  logic [NumWays-1:0] tag_req;
  logic [NumWays-1:0] data_req;
  logic               tag_we;
  icache_tag_entry_t  tag_wdata;

  ////////////////////////////////////////////////////////////
  // address and enables
  ////////////////////////////////////////////////////////////

  // set index comes from the FSM: flush counter, fetch or latched
  assign addr = ctrl_i.index[addr_w-1:0];

  // tag side is written both on flush and on refill
  assign tag_we          = ctrl_i.flush_en | ctrl_i.wren;
  // flush writes invalid entries
  assign tag_wdata.valid = ctrl_i.wren & ~ctrl_i.flush_en;
  assign tag_wdata.tag   = ctrl_i.tag;

  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    // all ways on lookup and flush, victim only on refill
    assign tag_req[i]  = ctrl_i.rden | ctrl_i.flush_en | (ctrl_i.wren & victim_oh_i[i]);
    assign data_req[i] = ctrl_i.rden | (ctrl_i.wren & victim_oh_i[i]);

    // tag and valid bit
    icache_sram #(
      .payload_t(icache_tag_entry_t),
      .NumWords (NumSets)
    ) i_tag_sram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (tag_req[i]),
      .we_i   (tag_we),
      .addr_i (addr),
      .wdata_i(tag_wdata),
      .rdata_o(tags_o[i])
    );

    // line data, written from the refill return
    icache_sram #(
      .payload_t(icache_line_t),
      .NumWords (NumSets)
    ) i_data_sram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (data_req[i]),
      .we_i   (ctrl_i.wren),
      .addr_i (addr),
      .wdata_i(rtrn_line_i),
      .rdata_o(lines_o[i])
    );
  end

endmodule

// ==== verilog/icache_sram.sv ====
`timescale 1ns/1ps

module icache_sram
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;
#(
  parameter type         payload_t = icache_line_t,
  parameter int unsigned NumWords  = num_sets
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  payload_t                    wdata_i,
  output payload_t                    rdata_o
);

  // storage array
  payload_t mem_q [NumWords];
  payload_t rdata_q;

  // write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read, output holds between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== verilog/icache_if_pkg.sv ====
package icache_if_pkg;
  import icache_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // basic words
  ////////////////////////////////////////////////////////////

  typedef logic [paddr_width-1:0] icache_paddr_t;
  typedef logic [line_width-1:0]  icache_line_t;
  typedef logic [fetch_width-1:0] icache_word_t;

  ////////////////////////////////////////////////////////////
  // fetch port
  ////////////////////////////////////////////////////////////

  // request strobe with aligned physical address
  typedef struct packed {
    logic          req;
    icache_paddr_t addr;
  } icache_fetch_req_t;

  // ready is a level, valid a single-cycle pulse
  typedef struct packed {
    logic         ready;
    logic         valid;
    icache_word_t data;
  } icache_fetch_rsp_t;

  ////////////////////////////////////////////////////////////
  // memory port
  ////////////////////////////////////////////////////////////

  // req held until ack, line address or word address when nc
  typedef struct packed {
    logic          req;
    icache_paddr_t addr;
    logic          nc;
  } icache_mem_req_t;

  // refill return, always one full line
  typedef struct packed {
    logic         valid;
    icache_line_t line;
  } icache_mem_rtrn_t;

  ////////////////////////////////////////////////////////////
  // internal
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 valid;
    logic [tag_width-1:0] tag;
  } icache_tag_entry_t;

  // strobes from the FSM to the arrays and the victim logic
  typedef struct packed {
    logic                   rden;
    logic                   wren;
    logic                   flush_en;
    logic [index_width-1:0] index;
    logic [tag_width-1:0]   tag;
  } icache_ctrl_t;

endpackage

// ==== verilog/icache_cfg_pkg.sv ====
package icache_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // address and data widths
  ////////////////////////////////////////////////////////////

  // physical fetch address, byte granular
  localparam int unsigned paddr_width  = 32;
  localparam int unsigned line_width   = 128;
  localparam int unsigned fetch_width  = 32;

  ////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////

  // address split is {tag, index, offset}
  localparam int unsigned offset_width = 4;
  localparam int unsigned num_sets     = 16;
  localparam int unsigned index_width  = 4;
  // whatever is left above index and offset
  localparam int unsigned tag_width    = paddr_width - index_width - offset_width;

  // default associativity
  localparam int unsigned num_ways     = 4;
  localparam int unsigned way_width    = 2;

  ////////////////////////////////////////////////////////////
  // uncached region
  ////////////////////////////////////////////////////////////

  // upper half of the address space bypasses the arrays
  localparam int unsigned nc_bit       = 31;

endpackage
